// File: all.f
common/busCpuPkg.sv
datapath/regFile.sv
datapath/shiftAlu.sv
datapath/busDatapath.sv
hw/controlSequencer.sv
hw/busCpuTop.sv
test/busCpuTb.sv

// File: common/busCpuPkg.sv
package busCpuPkg;

    localparam int dataWidth = 32;

    // instruction operations, codes from zero in this order
    typedef enum logic [4:0] {
        ldw,
        add,
        sub,
        andOp,
        orOp,
        shr,
        shl,
        ror,
        rol,
        neg,
        notOp
    } opcodeT;

    // one instruction word, msb first
    typedef struct packed {
        opcodeT      op;    // operation
        logic [3:0]  ra;    // destination register
        logic [3:0]  rb;    // first source
        logic [3:0]  rc;    // second source
        logic [14:0] imm;   // load address
    } instrT;

    // microsteps of one instruction
    typedef enum logic [2:0] {
        idle,
        t0,
        t1,
        t2,
        t3,
        t4,
        t5,
        done
    } stepT;

    // who drives the shared bus
    typedef enum logic [2:0] {
        none,
        pcSrc,
        mdrSrc,
        zSrc,
        regSrc,
        immSrc
    } busSrcT;

    typedef struct packed {
        busSrcT     busSrc;
        logic [3:0] regSel;  // register read onto the bus
        logic       regIn;
        logic       pcIn;
        logic       marIn;
        logic       mdrIn;
        logic       irIn;
        logic       yIn;
        logic       zIn;
        logic       incPc;   // z takes bus + 1 instead of the alu result
        opcodeT     aluOp;
    } ctrlT;

    // register write-back seen at the top level
    typedef struct packed {
        logic                 valid;
        logic [3:0]           regNum;
        logic [dataWidth-1:0] data;
    } wbT;

endpackage

// File: datapath/busDatapath.sv
`timescale 1ns/1ns

module busDatapath #(
    parameter int numRegs = 16
) (
    input  logic                            clock,
    input  logic                            rstN,
    input  busCpuPkg::ctrlT                 ctrl,
    input  logic [busCpuPkg::dataWidth-1:0] memRdata,
    input  logic                            memAck,
    output logic [busCpuPkg::dataWidth-1:0] memAddr,
    output busCpuPkg::instrT                ir,
    output busCpuPkg::wbT                   wb
);
    import busCpuPkg::*;

    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] y;
    logic [dataWidth-1:0] z;
    logic [dataWidth-1:0] regData;
    logic [dataWidth-1:0] aluResult;

    regFile #(
        .numRegs(numRegs)
    ) regs (
        .clock(clock),
        .rstN(rstN),
        .rdSel(ctrl.regSel),
        .wrEn(ctrl.regIn),
        .wrSel(ir.ra),
        .wrData(bus),
        .rdData(regData)
    );

    // y is the first operand, the bus carries the second
    shiftAlu alu (
        .op(ctrl.aluOp),
        .a(y),
        .b(bus),
        .result(aluResult)
    );

    // single shared bus
    always_comb begin
        case (ctrl.busSrc)
            pcSrc: begin
                bus = pc;
            end
            mdrSrc: begin
                bus = mdr;
            end
            zSrc: begin
                bus = z;
            end
            regSrc: begin
                bus = regData;
            end
            immSrc: begin
                bus = dataWidth'(ir.imm);   // zero extended address
            end
            default: begin
                bus = '0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= instrT'(bus);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= bus;
        end
        if (ctrl.mdrIn && memAck) begin
            mdr <= memRdata;    // capture on the ack edge
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= ctrl.incPc ? bus + dataWidth'(1) : aluResult;
        end
    end

    assign memAddr = mar;

    always_comb begin
        wb.valid  = ctrl.regIn;    // one cycle per write
        wb.regNum = ir.ra;
        wb.data   = bus;
    end

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ns

module regFile #(
    parameter int numRegs = 16
) (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [3:0]                      rdSel,
    input  logic                            wrEn,
    input  logic [3:0]                      wrSel,
    input  logic [busCpuPkg::dataWidth-1:0] wrData,
    output logic [busCpuPkg::dataWidth-1:0] rdData
);
    import busCpuPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    // read port drives the bus directly
    assign rdData = regs[rdSel];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;  // write from bus
        end
    end

endmodule

// File: datapath/shiftAlu.sv
`timescale 1ns/1ns

module shiftAlu (
    input  busCpuPkg::opcodeT               op,
    input  logic [busCpuPkg::dataWidth-1:0] a,
    input  logic [busCpuPkg::dataWidth-1:0] b,
    output logic [busCpuPkg::dataWidth-1:0] result
);
    import busCpuPkg::*;

    logic [4:0]             shamt;
    logic [2*dataWidth-1:0] rotRight;
    logic [2*dataWidth-1:0] rotLeft;

    assign shamt = b[4:0];  // only the low five bits count

    // doubled word, so the rotates fall out of plain shifts
    assign rotRight = {a, a} >> shamt;
    assign rotLeft  = {a, a} << shamt;

    always_comb begin
        case (op)
            add: begin
                result = a + b;
            end
            sub: begin
                result = a - b;
            end
            andOp: begin
                result = a & b;
            end
            orOp: begin
                result = a | b;
            end
            shr: begin
                result = a >> shamt;    // logical, zero fill
            end
            shl: begin
                result = a << shamt;
            end
            ror: begin
                result = rotRight[dataWidth-1:0];
            end
            rol: begin
                result = rotLeft[2*dataWidth-1:dataWidth];
            end
            neg: begin
                result = '0 - a;
            end
            notOp: begin
                result = ~a;
            end
            default: begin
                result = a;     // ldw and unused codes
            end
        endcase
    end

endmodule

// File: hw/busCpuTop.sv
`timescale 1ns/1ns

module busCpuTop #(
    parameter int numRegs = 16
) (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            runReq,
    input  logic                            memAck,
    input  logic [busCpuPkg::dataWidth-1:0] memRdata,
    output logic                            runAck,
    output logic                            memReq,
    output logic [busCpuPkg::dataWidth-1:0] memAddr,
    output busCpuPkg::wbT                   wb
);
    import busCpuPkg::*;

    ctrlT  ctrl;    // strobes for the current microstep
    instrT ir;      // decoded back in the sequencer

    controlSequencer sequencer (
        .clock(clock),
        .rstN(rstN),
        .runReq(runReq),
        .memAck(memAck),
        .ir(ir),
        .runAck(runAck),
        .memReq(memReq),
        .ctrl(ctrl)
    );

    busDatapath #(
        .numRegs(numRegs)
    ) datapath (
        .clock(clock),
        .rstN(rstN),
        .ctrl(ctrl),
        .memRdata(memRdata),
        .memAck(memAck),
        .memAddr(memAddr),
        .ir(ir),
        .wb(wb)
    );

endmodule

// File: hw/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer (
    input  logic             clock,
    input  logic             rstN,
    input  logic             runReq,
    input  logic             memAck,
    input  busCpuPkg::instrT ir,
    output logic             runAck,
    output logic             memReq,
    output busCpuPkg::ctrlT  ctrl
);
    import busCpuPkg::*;

    stepT step;
    stepT stepNext;
    logic memDone;      // data captured, ack still to fall
    logic isLoad;
    logic readStep;
    logic readOver;

    assign isLoad   = (ir.op == ldw);
    assign readStep = (step == t1) || (step == t4 && isLoad);
    assign readOver = memDone && !memAck;

    assign memReq = readStep && !memDone;
    assign runAck = (step == done);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step    <= idle;
            memDone <= 1'b0;
        end else begin
            step <= stepNext;
            if (memReq && memAck) begin
                memDone <= 1'b1;    // request drops from here on
            end else if (readOver) begin
                memDone <= 1'b0;
            end
        end
    end

    always_comb begin
        stepNext = step;
        case (step)
            idle: begin
                if (runReq) begin
                    stepNext = t0;
                end
            end
            t0: begin
                stepNext = t1;
            end
            t1: begin
                if (readOver) begin
                    stepNext = t2;
                end
            end
            t2: begin
                stepNext = t3;
            end
            t3: begin
                stepNext = t4;
            end
            t4: begin
                if (!isLoad || readOver) begin
                    stepNext = t5;
                end
            end
            t5: begin
                stepNext = done;
            end
            default: begin
                // hold the ack until the host lets go
                if (!runReq) begin
                    stepNext = idle;
                end
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (step)
            t0: begin
                ctrl.busSrc = pcSrc;
                ctrl.marIn  = 1'b1;
                ctrl.zIn    = 1'b1;
                ctrl.incPc  = 1'b1;
            end
            t1: begin
                ctrl.busSrc = zSrc;     // pc takes pc + 1 during the fetch
                ctrl.pcIn   = 1'b1;
                ctrl.mdrIn  = !memDone;
            end
            t2: begin
                ctrl.busSrc = mdrSrc;
                ctrl.irIn   = 1'b1;
            end
            t3: begin
                if (isLoad) begin
                    ctrl.busSrc = immSrc;
                    ctrl.marIn  = 1'b1;
                end else begin
                    ctrl.busSrc = regSrc;
                    ctrl.regSel = ir.rb;
                    ctrl.yIn    = 1'b1;
                end
            end
            t4: begin
                if (isLoad) begin
                    ctrl.mdrIn = !memDone;  // data read
                end else begin
                    ctrl.busSrc = regSrc;
                    ctrl.regSel = ir.rc;
                    ctrl.zIn    = 1'b1;
                    ctrl.aluOp  = ir.op;
                end
            end
            t5: begin
                if (isLoad) begin
                    ctrl.busSrc = mdrSrc;
                end else begin
                    ctrl.busSrc = zSrc;
                end
                ctrl.regIn = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module busCpuTb --Mdir build -f all.f

out=$(./build/VbusCpuTb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
    exit 0
fi
exit 1

// File: test/busCpuTb.sv
`timescale 1ns/1ns

module busCpuTb;
    import busCpuPkg::*;

    localparam int clockPeriod  = 8;
    localparam int memWords     = 128;    // program and data image
    localparam int expBase      = 128;    // expected triples start here
    localparam int numFileWords = 256;
    localparam int cyclesPerCase = 60;
    localparam logic [31:0] endMark = 32'hffff_ffff;

    logic                 clock = 1'b0;
    logic                 rstN;
    logic                 runReq;
    logic                 memAck;
    logic [dataWidth-1:0] memRdata;
    logic                 runAck;
    logic                 memReq;
    logic [dataWidth-1:0] memAddr;
    wbT                   wb;

    logic [31:0] fileWords [numFileWords];
    int          seed = 32'h25b6_289f;
    int          errors = 0;
    int          checks = 0;
    int          numCases = 0;
    logic        casesLoaded = 1'b0;

    busCpuTop #(
        .numRegs(16)
    ) UUT (
        .clock(clock),
        .rstN(rstN),
        .runReq(runReq),
        .memAck(memAck),
        .memRdata(memRdata),
        .runAck(runAck),
        .memReq(memReq),
        .memAddr(memAddr),
        .wb(wb)
    );

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [31:0] fileWord(int addr);
        return fileWords[8'(addr)];
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic expectTrue(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("** Failure at %0t ns: %s", $time, what);
        end
    endtask

    task automatic checkQuiet();
        expectTrue(!memReq, "memory request while no instruction runs");
        expectTrue(!wb.valid, "register write while no instruction runs");
    endtask

    task automatic loadCases();
        int base;
        for (int i = 0; i < numFileWords; i++) begin
            if (i < memWords) begin
                fileWords[8'(i)] = {16'hbad0, 16'(i)};  // unused memory words
            end else begin
                fileWords[8'(i)] = endMark;
            end
        end
        $readmemh("test/cpuCases.txt", fileWords);
        base = expBase;
        while (base + 2 < numFileWords && fileWord(base) != endMark) begin
            numCases++;
            base += 3;
        end
        expectTrue(numCases > 0, "no expected write-backs found in test/cpuCases.txt");
        casesLoaded = 1'b1;
    endtask

    // one run handshake, called on a rising edge
    task automatic runInstruction(int k);
        logic [31:0] expIndex;
        logic [31:0] expReg;
        logic [31:0] expData;
        logic        fetchSeen;
        int          wbSeen;
        int          hold;
        int          gap;
        expIndex  = fileWord(expBase + 3 * k);
        expReg    = fileWord(expBase + 3 * k + 1);
        expData   = fileWord(expBase + 3 * k + 2);
        fetchSeen = 1'b0;
        wbSeen    = 0;
        runReq <= 1'b1;
        do begin
            @(posedge clock);
            if (memReq && !fetchSeen) begin
                fetchSeen = 1'b1;
                checkValue("memAddr", expIndex, memAddr);   // fetch at pc
            end
            if (wb.valid) begin
                wbSeen++;
                checkValue("wb.regNum", expReg, 32'(wb.regNum));
                checkValue("wb.data", expData, wb.data);
            end
        end while (!runAck);
        expectTrue(fetchSeen, "instruction finished without a memory fetch");
        expectTrue(wbSeen == 1, "instruction did not write exactly one register");

        // keep runReq up for a while, the sequencer must sit in done
        hold = $unsigned($random(seed)) % 4;
        repeat (hold) begin
            @(posedge clock);
            expectTrue(runAck, "runAck dropped while runReq was still high");
            checkQuiet();
        end
        runReq <= 1'b0;
        do begin
            @(posedge clock);
            checkQuiet();
        end while (runAck);
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) begin
            @(posedge clock);
            expectTrue(!runAck, "runAck rose without a run request");
            checkQuiet();
        end
    endtask

    // memory model, ack after 0 to 3 cycles
    initial begin
        int delay;
        forever begin
            @(posedge clock);
            if (memReq && !memAck) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clock);
                expectTrue(memAddr < memWords, "memory read outside the image");
                memRdata <= fileWords[memAddr[7:0]];
                memAck   <= 1'b1;
                do begin
                    @(posedge clock);
                end while (memReq);
                memAck <= 1'b0;     // four-phase release
            end
        end
    end

    initial begin
        rstN     = 1'b0;
        runReq   = 1'b0;
        memAck   = 1'b0;
        memRdata = '0;
        loadCases();
        repeat (2) @(posedge clock);
        rstN <= 1'b1;
        repeat (3) begin
            @(posedge clock);
            expectTrue(!runAck, "runAck high before the first run");
            checkQuiet();
        end
        for (int k = 0; k < numCases; k++) begin
            runInstruction(k);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, sized from the number of cases
    initial begin
        wait (casesLoaded);
        #((numCases * cyclesPerCase + 20) * clockPeriod);
        $display("** Timeout at %0t ns: the program did not finish in time", $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: test/cpuCases.txt
// words 000-07f: memory image, instructions from 000, data words from 060
// words 080 on: expected triples, one per line: fetch address, register, value
@000
00800060 01000061 01800062 02000063
2A890000 33090000 3BA10000 44210000
0C8A0000 15208000 1D8A0000 260A0000
4EA00000 57180000 10190000 2FA18000
@060
fff0ffff 00000004 00000000 12345678
@080
00000000 00000001 fff0ffff
00000001 00000002 00000004
00000002 00000003 00000000
00000003 00000004 12345678
00000004 00000005 0fff0fff
00000005 00000006 ff0ffff0
00000006 00000007 81234567
00000007 00000008 23456781
00000008 00000009 12255677
00000009 0000000a 12435679
0000000a 0000000b 12305678
0000000b 0000000c fff4ffff
0000000c 0000000d edcba988
0000000d 0000000e ffffffff
0000000e 00000000 fffffffc
0000000f 0000000f 12345678
